//--- include/core_io_defines.svh
`ifndef CORE_IO_DEFINES_SVH
`define CORE_IO_DEFINES_SVH

// Bus and field widths
`define CIO_DATA_W          32
`define CIO_ADDR_W          6
`define CIO_DESC_W          64
`define CIO_TAG_W           5
`define CIO_MASK_W          16

// Reset values
`define CIO_MASK_RESET      16'hFFF0
`define CIO_STEP_RESET      32'd1

// Write register word addresses
`define CIO_SEND_DESC_L     6'h02
`define CIO_SEND_DESC_H     6'h03
`define CIO_WR_DRAM_L       6'h04
`define CIO_WR_DRAM_H       6'h05
`define CIO_TIMER_STEP      6'h07
`define CIO_DRAM_FLAG       6'h08
`define CIO_SEND_DESC_TYPE  6'h0A
`define CIO_RD_DESC_STRB    6'h0B
`define CIO_DRAM_FLAG_RST   6'h0C
`define CIO_MASK_WR         6'h0E
`define CIO_INT_ACK         6'h0F

// Read register word addresses
`define CIO_RD_DESC_L       6'h20
`define CIO_RD_DESC_H       6'h21
`define CIO_RD_DFLAGS       6'h22
`define CIO_RD_STAT         6'h23
`define CIO_RD_ID           6'h24
`define CIO_RD_TIMER_L      6'h25
`define CIO_RD_TIMER_H      6'h26
`define CIO_RD_INT_F        6'h27
`define CIO_RD_MASK         6'h28

// Interrupt flag and mask bit positions
`define CIO_IRQ_TIMER       0
`define CIO_IRQ_IN_DESC     1
`define CIO_IRQ_DRAM        2
`define CIO_IRQ_POKE        4
`define CIO_IRQ_EVICT       5

`endif

//--- logic/core_io_pkg.sv
`default_nettype none

`include "core_io_defines.svh"

package core_io_pkg;

  // One word of the core bus
  typedef logic [`CIO_DATA_W-1:0]   word_t;

  // Byte enables of a bus word
  typedef logic [`CIO_DATA_W/8-1:0] strb_t;

  // Register word address inside the I/O window
  typedef logic [`CIO_ADDR_W-1:0]   io_addr_t;

  // Packet descriptor or DRAM address
  typedef logic [`CIO_DESC_W-1:0]   desc_t;

  // DRAM receive tag
  typedef logic [`CIO_TAG_W-1:0]    dram_tag_t;

  // Interrupt mask or flag vector
  typedef logic [`CIO_MASK_W-1:0]   irq_mask_t;

endpackage

`default_nettype wire

//--- logic/io_wr_if.sv
`default_nettype none

`include "core_io_defines.svh"

// Accepted register writes, one pulse per write
interface io_wr_if;

  logic                     wr;
  logic [`CIO_ADDR_W-1:0]   addr;
  logic [`CIO_DATA_W-1:0]   wdata;
  logic [`CIO_DATA_W/8-1:0] strb;

  modport master (output wr, output addr, output wdata, output strb);

  modport slave (input wr, input addr, input wdata, input strb);

endinterface

`default_nettype wire

//--- logic/io_write_regs.sv
`default_nettype none

`include "core_io_defines.svh"

module io_write_regs (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        io_valid,
  input  wire                        io_we,
  input  wire core_io_pkg::io_addr_t io_addr,
  input  wire core_io_pkg::word_t    io_wdata,
  input  wire core_io_pkg::strb_t    io_strb,
  input  wire                        out_desc_ready,
  output logic                       io_ready,
  output core_io_pkg::desc_t         out_desc,
  output core_io_pkg::desc_t         out_desc_dram_addr,
  output logic                       out_desc_valid,
  output logic                       in_desc_taken,
  io_wr_if.master                    wr_bus
);
  import core_io_pkg::*;

  desc_t      desc_data_r;
  desc_t      dram_addr_r;
  logic [3:0] desc_type_r;
  logic       desc_valid_r;
  logic       desc_word;
  logic       send_addr;
  logic       wr_acc;

  //////////////////////////////////////////////////////////////////////
  // Write acceptance

  assign desc_word = (io_addr == `CIO_SEND_DESC_L) || (io_addr == `CIO_SEND_DESC_H) ||
                     (io_addr == `CIO_WR_DRAM_L)   || (io_addr == `CIO_WR_DRAM_H);
  assign send_addr = (io_addr == `CIO_SEND_DESC_TYPE);

  // Descriptor words stall while the previous descriptor is still pending
  assign io_ready = !(io_we && (desc_word || send_addr) && desc_valid_r && !out_desc_ready);
  assign wr_acc   = io_valid && io_ready && io_we;

  assign wr_bus.wr    = wr_acc;
  assign wr_bus.addr  = io_addr;
  assign wr_bus.wdata = io_wdata;
  assign wr_bus.strb  = io_strb;

  //////////////////////////////////////////////////////////////////////
  // Outgoing descriptor registers

  always_ff @(posedge clk) begin
    if (wr_acc) begin
      for (int i = 0; i < `CIO_DATA_W/8; i++) begin
        if (io_strb[i]) begin
          case (io_addr)
            `CIO_SEND_DESC_L: desc_data_r[i*8 +: 8] <= io_wdata[i*8 +: 8];
            `CIO_SEND_DESC_H: desc_data_r[`CIO_DATA_W + i*8 +: 8] <= io_wdata[i*8 +: 8];
            `CIO_WR_DRAM_L:   dram_addr_r[i*8 +: 8] <= io_wdata[i*8 +: 8];
            `CIO_WR_DRAM_H:   dram_addr_r[`CIO_DATA_W + i*8 +: 8] <= io_wdata[i*8 +: 8];
            default: ;
          endcase
        end
      end
      // Type write also launches the descriptor
      if (send_addr) begin
        desc_type_r <= io_wdata[3:0];
      end
    end
  end

  // A new send in the handshake cycle keeps valid high for the next one
  always_ff @(posedge clk) begin
    if (rst) begin
      desc_valid_r <= 1'b0;
    end else if (wr_acc && send_addr) begin
      desc_valid_r <= 1'b1;
    end else if (out_desc_ready) begin
      desc_valid_r <= 1'b0;
    end
  end

  assign out_desc           = {desc_type_r, desc_data_r[`CIO_DESC_W-5:0]};
  assign out_desc_dram_addr = dram_addr_r;
  assign out_desc_valid     = desc_valid_r;

  // Incoming descriptor release
  assign in_desc_taken = wr_acc && (io_addr == `CIO_RD_DESC_STRB) && io_wdata[0];

  a_desc_hold: assert property (@(posedge clk) disable iff (rst)
    out_desc_valid && !out_desc_ready |=> out_desc_valid);

endmodule

`default_nettype wire

//--- logic/irq_ctrl.sv
`default_nettype none

`include "core_io_defines.svh"

module irq_ctrl (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    in_desc_valid,
  input  wire                    dram_recv_any,
  input  wire                    timer_irq,
  input  wire                    poke_int,
  input  wire                    evict_int,
  output logic                   core_interrupt,
  output logic                   poke_int_ack,
  output logic                   evict_int_ack,
  output logic                   timer_ack,
  output core_io_pkg::irq_mask_t irq_flags,
  output core_io_pkg::irq_mask_t irq_mask,
  io_wr_if.slave                 wr_bus
);
  import core_io_pkg::*;

  irq_mask_t pending;
  logic      ack_wr;

  assign ack_wr = wr_bus.wr && (wr_bus.addr == `CIO_INT_ACK);

  always_ff @(posedge clk) begin
    if (rst) begin
      irq_mask <= `CIO_MASK_RESET;
    end else if (wr_bus.wr && (wr_bus.addr == `CIO_MASK_WR)) begin
      irq_mask <= wr_bus.wdata[`CIO_MASK_W-1:0];
    end
  end

  // Raw sources, readable by software before masking
  always_comb begin
    irq_flags                   = '0;
    irq_flags[`CIO_IRQ_TIMER]   = timer_irq;
    irq_flags[`CIO_IRQ_IN_DESC] = in_desc_valid;
    irq_flags[`CIO_IRQ_DRAM]    = dram_recv_any;
    irq_flags[`CIO_IRQ_POKE]    = poke_int;
    irq_flags[`CIO_IRQ_EVICT]   = evict_int;
  end

  assign pending = irq_flags & irq_mask;

  // Sources hold until released, so dropping the line for one cycle
  // on an ack lets the handler see the true state afterwards
  always_ff @(posedge clk) begin
    if (rst) begin
      core_interrupt <= 1'b0;
    end else begin
      core_interrupt <= !ack_wr && (|pending);
    end
  end

  // in_desc and dram flags are cleared through their own registers
  assign timer_ack     = ack_wr && wr_bus.wdata[`CIO_IRQ_TIMER];
  assign poke_int_ack  = ack_wr && wr_bus.wdata[`CIO_IRQ_POKE];
  assign evict_int_ack = ack_wr && wr_bus.wdata[`CIO_IRQ_EVICT];

endmodule

`default_nettype wire

//--- logic/interval_timer.sv
`default_nettype none

`include "core_io_defines.svh"

module interval_timer (
  input  wire    clk,
  input  wire    rst,
  input  wire    timer_ack,
  output logic   timer_irq,
  io_wr_if.slave wr_bus
);
  import core_io_pkg::*;

  word_t step_r;
  word_t count_r;
  logic  step_wr;

  assign step_wr = wr_bus.wr && (wr_bus.addr == `CIO_TIMER_STEP);

  // Byte-writable step
  always_ff @(posedge clk) begin
    if (rst) begin
      step_r <= `CIO_STEP_RESET;
    end else if (step_wr) begin
      for (int i = 0; i < `CIO_DATA_W/8; i++) begin
        if (wr_bus.strb[i]) begin
          step_r[i*8 +: 8] <= wr_bus.wdata[i*8 +: 8];
        end
      end
    end
  end

  // New step restarts the interval from zero
  always_ff @(posedge clk) begin
    if (rst || step_wr) begin
      count_r   <= '0;
      timer_irq <= 1'b0;
    end else if (count_r == step_r) begin
      count_r   <= '0;
      timer_irq <= 1'b1;
    end else begin
      count_r <= count_r + 1'b1;
      if (timer_ack) begin
        timer_irq <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/dram_recv_flags.sv
`default_nettype none

`include "core_io_defines.svh"

module dram_recv_flags (
  input  wire                     clk,
  input  wire                     rst,
  input  wire core_io_pkg::dram_tag_t recv_dram_tag,
  input  wire                     recv_dram_tag_valid,
  output core_io_pkg::word_t      dram_flags,
  output logic                    dram_recv_any,
  io_wr_if.slave                  wr_bus
);
  import core_io_pkg::*;

  dram_tag_t tag_r;
  logic      tag_valid_r;
  logic      flag_wr;
  logic      flag_clr;

  // Input stage for timing
  always_ff @(posedge clk) begin
    tag_r <= recv_dram_tag;
    if (rst) begin
      tag_valid_r <= 1'b0;
    end else begin
      tag_valid_r <= recv_dram_tag_valid;
    end
  end

  assign flag_wr  = wr_bus.wr && (wr_bus.addr == `CIO_DRAM_FLAG);
  assign flag_clr = wr_bus.wr && (wr_bus.addr == `CIO_DRAM_FLAG_RST);

  // Later assignments win, so a tag arrival beats a clear of its bit
  always_ff @(posedge clk) begin
    if (rst) begin
      dram_flags <= '0;
    end else begin
      if (flag_wr) begin
        for (int i = 0; i < `CIO_DATA_W/8; i++) begin
          if (wr_bus.strb[i]) begin
            dram_flags[i*8 +: 8] <= wr_bus.wdata[i*8 +: 8];
          end
        end
      end
      if (flag_clr) begin
        dram_flags[wr_bus.wdata[`CIO_TAG_W-1:0]] <= 1'b0;
      end
      if (tag_valid_r) begin
        dram_flags[tag_r] <= 1'b1;
      end
      // Tag 0 is reserved
      dram_flags[0] <= 1'b0;
    end
  end

  assign dram_recv_any = |dram_flags;

  a_tag0_clear: assert property (@(posedge clk) disable iff (rst) !dram_flags[0]);

endmodule

`default_nettype wire

//--- logic/io_read_mux.sv
`default_nettype none

`include "core_io_defines.svh"

module io_read_mux (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        io_valid,
  input  wire                        io_we,
  input  wire core_io_pkg::io_addr_t io_addr,
  input  wire core_io_pkg::desc_t    in_desc,
  input  wire                        in_desc_valid,
  input  wire                        out_desc_valid,
  input  wire                        out_desc_ready,
  input  wire [7:0]                  core_id,
  input  wire core_io_pkg::desc_t    timer,
  input  wire core_io_pkg::word_t    dram_flags,
  input  wire core_io_pkg::irq_mask_t irq_flags,
  input  wire core_io_pkg::irq_mask_t irq_mask,
  output logic                       io_rvalid,
  output core_io_pkg::word_t         io_rdata
);
  import core_io_pkg::*;

  word_t stat_word;
  logic  rd_acc;

  // Reads are never stalled
  assign rd_acc = io_valid && !io_we;

  // Bit 16 shows a descriptor still waiting on the send side
  always_comb begin
    stat_word     = '0;
    stat_word[0]  = in_desc_valid;
    stat_word[8]  = out_desc_ready;
    stat_word[16] = out_desc_valid;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      io_rvalid <= 1'b0;
    end else begin
      io_rvalid <= rd_acc;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_acc) begin
      case (io_addr)
        `CIO_RD_DESC_L: begin
          if (in_desc_valid) begin
            io_rdata <= in_desc[`CIO_DATA_W-1:0];
          end
        end
        `CIO_RD_DESC_H: begin
          if (in_desc_valid) begin
            io_rdata <= in_desc[`CIO_DESC_W-1:`CIO_DATA_W];
          end
        end
        `CIO_RD_DFLAGS:  io_rdata <= dram_flags;
        `CIO_RD_STAT:    io_rdata <= stat_word;
        `CIO_RD_ID:      io_rdata <= {{(`CIO_DATA_W-8){1'b0}}, core_id};
        `CIO_RD_TIMER_L: io_rdata <= timer[`CIO_DATA_W-1:0];
        `CIO_RD_TIMER_H: io_rdata <= timer[`CIO_DESC_W-1:`CIO_DATA_W];
        `CIO_RD_INT_F:   io_rdata <= {{(`CIO_DATA_W-`CIO_MASK_W){1'b0}}, irq_flags};
        `CIO_RD_MASK:    io_rdata <= {{(`CIO_DATA_W-`CIO_MASK_W){1'b0}}, irq_mask};
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/core_io_top.sv
`default_nettype none

module core_io_top (
  input  wire                         clk,
  input  wire                         rst,
  // Core bus
  input  wire                         io_valid,
  input  wire                         io_we,
  input  wire core_io_pkg::io_addr_t  io_addr,
  input  wire core_io_pkg::word_t     io_wdata,
  input  wire core_io_pkg::strb_t     io_strb,
  output logic                        io_ready,
  output logic                        io_rvalid,
  output core_io_pkg::word_t          io_rdata,
  // Outgoing descriptor
  output core_io_pkg::desc_t          out_desc,
  output core_io_pkg::desc_t          out_desc_dram_addr,
  output logic                        out_desc_valid,
  input  wire                         out_desc_ready,
  // Incoming descriptor
  input  wire core_io_pkg::desc_t     in_desc,
  input  wire                         in_desc_valid,
  output logic                        in_desc_taken,
  // Status
  input  wire [7:0]                   core_id,
  input  wire core_io_pkg::desc_t     timer,
  // Interrupts
  input  wire                         poke_int,
  output logic                        poke_int_ack,
  input  wire                         evict_int,
  output logic                        evict_int_ack,
  input  wire core_io_pkg::dram_tag_t recv_dram_tag,
  input  wire                         recv_dram_tag_valid,
  output logic                        core_interrupt
);
  import core_io_pkg::*;

  word_t     dram_flags;
  irq_mask_t irq_flags;
  irq_mask_t irq_mask;
  logic      dram_recv_any;
  logic      timer_irq;
  logic      timer_ack;

  io_wr_if wr_bus ();

  io_write_regs u_write_regs (
    .clk                (clk),
    .rst                (rst),
    .io_valid           (io_valid),
    .io_we              (io_we),
    .io_addr            (io_addr),
    .io_wdata           (io_wdata),
    .io_strb            (io_strb),
    .out_desc_ready     (out_desc_ready),
    .io_ready           (io_ready),
    .out_desc           (out_desc),
    .out_desc_dram_addr (out_desc_dram_addr),
    .out_desc_valid     (out_desc_valid),
    .in_desc_taken      (in_desc_taken),
    .wr_bus             (wr_bus.master)
  );

  irq_ctrl u_irq_ctrl (
    .clk            (clk),
    .rst            (rst),
    .in_desc_valid  (in_desc_valid),
    .dram_recv_any  (dram_recv_any),
    .timer_irq      (timer_irq),
    .poke_int       (poke_int),
    .evict_int      (evict_int),
    .core_interrupt (core_interrupt),
    .poke_int_ack   (poke_int_ack),
    .evict_int_ack  (evict_int_ack),
    .timer_ack      (timer_ack),
    .irq_flags      (irq_flags),
    .irq_mask       (irq_mask),
    .wr_bus         (wr_bus.slave)
  );

  interval_timer u_timer (
    .clk       (clk),
    .rst       (rst),
    .timer_ack (timer_ack),
    .timer_irq (timer_irq),
    .wr_bus    (wr_bus.slave)
  );

  dram_recv_flags u_dram_flags (
    .clk                 (clk),
    .rst                 (rst),
    .recv_dram_tag       (recv_dram_tag),
    .recv_dram_tag_valid (recv_dram_tag_valid),
    .dram_flags          (dram_flags),
    .dram_recv_any       (dram_recv_any),
    .wr_bus              (wr_bus.slave)
  );

  io_read_mux u_read_mux (
    .clk            (clk),
    .rst            (rst),
    .io_valid       (io_valid),
    .io_we          (io_we),
    .io_addr        (io_addr),
    .in_desc        (in_desc),
    .in_desc_valid  (in_desc_valid),
    .out_desc_valid (out_desc_valid),
    .out_desc_ready (out_desc_ready),
    .core_id        (core_id),
    .timer          (timer),
    .dram_flags     (dram_flags),
    .irq_flags      (irq_flags),
    .irq_mask       (irq_mask),
    .io_rvalid      (io_rvalid),
    .io_rdata       (io_rdata)
  );

endmodule

`default_nettype wire

//--- tests/core_io_tb.sv
`default_nettype none

`include "core_io_defines.svh"

module core_io_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import core_io_pkg::*;

  typedef logic [8*16-1:0] tok_t;

  localparam string VECTOR_FILE = "tests/core_io_vectors.txt";

  logic      clk;
  logic      rst;
  logic      io_valid;
  logic      io_we;
  io_addr_t  io_addr;
  word_t     io_wdata;
  strb_t     io_strb;
  logic      io_ready;
  logic      io_rvalid;
  word_t     io_rdata;
  desc_t     out_desc;
  desc_t     out_desc_dram_addr;
  logic      out_desc_valid;
  logic      out_desc_ready;
  desc_t     in_desc;
  logic      in_desc_valid;
  logic      in_desc_taken;
  logic [7:0] core_id;
  desc_t     timer;
  logic      poke_int;
  logic      poke_int_ack;
  logic      evict_int;
  logic      evict_int_ack;
  dram_tag_t recv_dram_tag;
  logic      recv_dram_tag_valid;
  logic      core_interrupt;

  // Current vector line
  tok_t             op;
  tok_t             test_name;
  tok_t             target;
  word_t            value;
  word_t            extra;
  logic [8*200-1:0] line_buf;

  int   fd;
  logic got;
  int   vector_count = 0;
  int   cycle_count = 0;
  int   cycle_limit = 200;
  int   taken_count = 0;
  int   poke_ack_count = 0;
  int   evict_ack_count = 0;

  core_io_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Pulse counters and the watchdog run on the falling edge
  always @(negedge clk) begin
    cycle_count++;
    if (in_desc_taken) taken_count++;
    if (poke_int_ack) poke_ack_count++;
    if (evict_int_ack) evict_ack_count++;
    if (cycle_count > cycle_limit) begin
      stop_on_error($sformatf("timeout after %0d cycles", cycle_count));
    end
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Vector file access

  // Skips comment lines and leaves the fields of the next vector in place
  task automatic read_vector(output logic ok);
    int n;
    ok = 1'b0;
    n = $fscanf(fd, "%s", op);
    while (n == 1 && op == tok_t'("#")) begin
      n = $fgets(line_buf, fd);
      n = $fscanf(fd, "%s", op);
    end
    if (n == 1) begin
      n = $fscanf(fd, "%s %s %h %h", test_name, target, value, extra);
      ok = (n == 4);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus and pin operations

  task automatic bus_write(input io_addr_t addr, input word_t data, input strb_t strb);
    io_valid = 1'b1;
    io_we    = 1'b1;
    io_addr  = addr;
    io_wdata = data;
    io_strb  = strb;
    @(negedge clk);
    while (!io_ready) @(negedge clk);
    next_cycle();
    io_valid = 1'b0;
    io_we    = 1'b0;
    // Registered effects of the write show one cycle later
    next_cycle();
  endtask

  // Response comes one cycle after acceptance and lasts one cycle
  task automatic bus_read(input io_addr_t addr, output word_t data);
    io_valid = 1'b1;
    io_we    = 1'b0;
    io_addr  = addr;
    next_cycle();
    io_valid = 1'b0;
    @(negedge clk);
    assert (io_rvalid)
      else stop_on_error($sformatf("read of address %h got no response in %0s", addr, test_name));
    data = io_rdata;
    @(negedge clk);
    assert (!io_rvalid)
      else stop_on_error($sformatf("read response lasted more than one cycle in %0s", test_name));
    next_cycle();
  endtask

  // Holds a write that must not be accepted and then withdraws it
  task automatic stall_write(input io_addr_t addr, input word_t data, input int cycles);
    io_valid = 1'b1;
    io_we    = 1'b1;
    io_addr  = addr;
    io_wdata = data;
    io_strb  = 4'hf;
    repeat (cycles) begin
      @(negedge clk);
      assert (!io_ready)
        else stop_on_error($sformatf("error %0s: expected 0, actual %b", test_name, io_ready));
    end
    next_cycle();
    io_valid = 1'b0;
    io_we    = 1'b0;
  endtask

  task automatic poll_read(input io_addr_t addr, input word_t bits, input int bound);
    word_t data;
    int    start;
    start = cycle_count;
    bus_read(addr, data);
    while ((data & bits) != bits && cycle_count - start < bound) begin
      bus_read(addr, data);
    end
    assert ((data & bits) == bits)
      else stop_on_error($sformatf("error %0s: expected %h, actual %h", test_name, bits, data));
  endtask

  task automatic set_pin(input tok_t name, input word_t val);
    if (name == tok_t'("out_desc_ready")) out_desc_ready = val[0];
    else if (name == tok_t'("in_desc_valid")) in_desc_valid = val[0];
    else if (name == tok_t'("in_desc_l")) in_desc[31:0] = val;
    else if (name == tok_t'("in_desc_h")) in_desc[63:32] = val;
    else if (name == tok_t'("core_id")) core_id = val[7:0];
    else if (name == tok_t'("poke_int")) poke_int = val[0];
    else if (name == tok_t'("evict_int")) evict_int = val[0];
    else if (name == tok_t'("tag")) begin
      recv_dram_tag       = dram_tag_t'(val);
      recv_dram_tag_valid = 1'b1;
    end else begin
      stop_on_error($sformatf("unknown pin %0s in %0s", name, test_name));
    end
    next_cycle();
    recv_dram_tag_valid = 1'b0;
  endtask

  task automatic read_output(input tok_t name, output word_t actual);
    if (name == tok_t'("out_desc_valid")) actual = word_t'(out_desc_valid);
    else if (name == tok_t'("out_desc_h")) actual = out_desc[63:32];
    else if (name == tok_t'("out_desc_l")) actual = out_desc[31:0];
    else if (name == tok_t'("dram_addr_h")) actual = out_desc_dram_addr[63:32];
    else if (name == tok_t'("dram_addr_l")) actual = out_desc_dram_addr[31:0];
    else if (name == tok_t'("core_interrupt")) actual = word_t'(core_interrupt);
    else if (name == tok_t'("taken_count")) actual = word_t'(taken_count);
    else if (name == tok_t'("poke_ack_count")) actual = word_t'(poke_ack_count);
    else begin
      actual = '0;
      stop_on_error($sformatf("unknown output %0s in %0s", name, test_name));
    end
  endtask

  task automatic wait_output(input tok_t name, input word_t expected, input int bound);
    word_t actual;
    int    waited;
    waited = 0;
    read_output(name, actual);
    while (actual != expected && waited < bound) begin
      next_cycle();
      waited++;
      read_output(name, actual);
    end
    assert (actual == expected)
      else stop_on_error($sformatf("error %0s: expected %h, actual %h",
                                   test_name, expected, actual));
  endtask

  // Evict source through the mask and its acknowledge pulse
  task automatic check_evict_ack();
    test_name = tok_t'("t6_evict");
    evict_int = 1'b1;
    next_cycle();
    assert (core_interrupt)
      else stop_on_error($sformatf("error %0s: expected 1, actual %b",
                                   test_name, core_interrupt));
    bus_write(`CIO_INT_ACK, 32'h1 << `CIO_IRQ_EVICT, 4'hf);
    assert (evict_ack_count == 1)
      else stop_on_error($sformatf("error %0s: expected %h, actual %h",
                                   test_name, 32'd1, evict_ack_count));
    assert (poke_ack_count == 1)
      else stop_on_error($sformatf("error %0s: expected %h, actual %h",
                                   test_name, 32'd1, poke_ack_count));
    evict_int = 1'b0;
  endtask

  task automatic run_vector();
    word_t    addr_word;
    io_addr_t addr;
    word_t    data;
    int       n;
    addr_word = '0;
    if (op == tok_t'("wr") || op == tok_t'("rd") || op == tok_t'("stall") ||
        op == tok_t'("poll")) begin
      n = $sscanf(target, "%h", addr_word);
    end
    addr = io_addr_t'(addr_word);
    if (op == tok_t'("wr")) bus_write(addr, value, strb_t'(extra));
    else if (op == tok_t'("rd")) begin
      bus_read(addr, data);
      assert (data == value)
        else stop_on_error($sformatf("error %0s: expected %h, actual %h", test_name, value, data));
    end
    else if (op == tok_t'("pin")) set_pin(target, value);
    else if (op == tok_t'("wait")) wait_output(target, value, int'(extra));
    else if (op == tok_t'("stall")) stall_write(addr, value, int'(extra));
    else if (op == tok_t'("poll")) poll_read(addr, value, int'(extra));
    else if (op == tok_t'("idle")) repeat (value) next_cycle();
    else stop_on_error($sformatf("unknown vector operation %0s", op));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    rst                 = 1'b1;
    io_valid            = 1'b0;
    io_we               = 1'b0;
    io_addr             = '0;
    io_wdata            = '0;
    io_strb             = '0;
    out_desc_ready      = 1'b0;
    in_desc             = '0;
    in_desc_valid       = 1'b0;
    core_id             = '0;
    timer               = 64'h0000_0001_0000_0000;
    poke_int            = 1'b0;
    evict_int           = 1'b0;
    recv_dram_tag       = '0;
    recv_dram_tag_valid = 1'b0;

    // First pass sizes the watchdog limit
    fd = $fopen(VECTOR_FILE, "r");
    if (fd == 0) stop_on_error("cannot open the vector file");
    read_vector(got);
    while (got) begin
      cycle_limit += 40;
      read_vector(got);
    end
    $fclose(fd);

    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    fd = $fopen(VECTOR_FILE, "r");
    read_vector(got);
    while (got) begin
      run_vector();
      vector_count++;
      read_vector(got);
    end
    $fclose(fd);

    check_evict_ack();

    if (vector_count > 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      stop_on_error("no vectors were read");
    end
  end

endmodule

`default_nettype wire

//--- tests/core_io_vectors.txt
# op test target value extra (values in hex)
# wr addr data strb, rd addr expected, pin/wait name value bound, stall/poll addr data bound
# descriptor send and back-pressure
wr t1_desc_l 02 11223344 f
wr t1_desc_h 03 a5667788 f
wr t1_dram_l 04 00001000 f
wr t1_dram_h 05 00000002 f
wr t1_type 0a 00000005 f
wait t1_valid out_desc_valid 1 2
wait t1_desc_h out_desc_h 55667788 0
wait t1_desc_l out_desc_l 11223344 0
wait t1_dram_h dram_addr_h 00000002 0
wait t1_dram_l dram_addr_l 00001000 0
stall t1_stall 02 deadbeef 4
wait t1_held out_desc_valid 1 0
pin t1_ready out_desc_ready 1 0
wait t1_released out_desc_valid 0 2
wr t1_retry 02 deadbeef f
wait t1_retry_l out_desc_l deadbeef 0
# register reads and descriptor release
pin t2_core_id core_id 2a 0
rd t2_rd_id 24 0000002a 0
pin t2_in_desc_l in_desc_l cafe0001 0
pin t2_in_desc_h in_desc_h 0badf00d 0
pin t2_in_valid in_desc_valid 1 0
rd t2_rd_desc_l 20 cafe0001 0
rd t2_rd_desc_h 21 0badf00d 0
rd t2_rd_stat 23 00000101 0
pin t2_ready_low out_desc_ready 0 0
rd t2_rd_stat_lo 23 00000001 0
wr t2_release 0b 00000001 f
wait t2_taken taken_count 1 0
pin t2_in_idle in_desc_valid 0 0
# DRAM receive flags
pin t3_tag3 tag 3 0
pin t3_tag0 tag 0 0
rd t3_flags 22 00000008 0
wr t3_clear 0c 00000003 f
rd t3_cleared 22 00000000 0
wr t3_byte 08 000000ff 1
rd t3_byte_rd 22 000000fe 0
wr t3_zero 08 00000000 f
# interrupts
wait t4_quiet core_interrupt 0 0
pin t4_poke poke_int 1 0
wait t4_irq core_interrupt 1 3
wr t4_ack 0f 00000010 f
wait t4_ack_pulse poke_ack_count 1 0
wr t4_mask 0e 0000ffe0 f
rd t4_mask_rd 28 0000ffe0 0
wait t4_masked core_interrupt 0 2
idle t4_hold - 4 0
wait t4_still_low core_interrupt 0 0
rd t4_flags 27 00000011 0
pin t4_poke_off poke_int 0 0
# interval timer
wr t5_step 07 0000000a f
poll t5_timer 27 00000001 28
wr t5_ack 0f 00000001 f
rd t5_acked 27 00000000 0

//--- files.f
+incdir+include
logic/core_io_pkg.sv
logic/io_wr_if.sv
logic/io_write_regs.sv
logic/irq_ctrl.sv
logic/interval_timer.sv
logic/dram_recv_flags.sv
logic/io_read_mux.sv
logic/core_io_top.sv
tests/core_io_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
rm -f sim.log build.log
verilator --binary --assert --timescale 1ns/1ps -f files.f --top-module core_io_tb \
  -o core_io_sim > build.log 2>&1 \
  && ./obj_dir/core_io_sim > sim.log 2>&1 \
  || { cat build.log; echo "SOME TESTS FAILED" >> sim.log; }
cat sim.log
if grep -q "SOME TESTS FAILED" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
exit 0
